// ==== hdl/seq_pkg.sv ====
`default_nettype none

package seq_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////

  // Instruction IDs that may be in flight
  localparam int unsigned NR_VINSN = 8;
  // Architectural vector registers
  localparam int unsigned NR_VREGS = 32;
  // ALU, multiplier and LSU
  localparam int unsigned NR_UNITS = 3;
  // Mask register, read by masked instructions
  localparam int unsigned VMASK    = 0;

  typedef logic [$clog2(NR_VINSN)-1:0] vid_t;
  typedef logic [$clog2(NR_VREGS)-1:0] vreg_t;
  // One bit per instruction ID
  typedef logic [NR_VINSN-1:0]         vinsn_vec_t;
  // One bit per execution unit
  typedef logic [NR_UNITS-1:0]         unit_vec_t;

  typedef enum logic [1:0] {
    OP_VADD   = 2'd0,
    OP_VMUL   = 2'd1,
    OP_VLOAD  = 2'd2,
    OP_VSTORE = 2'd3
  } op_e;

  // Value doubles as the index into unit vectors
  typedef enum logic [1:0] {
    UNIT_ALU = 2'd0,
    UNIT_MUL = 2'd1,
    UNIT_LSU = 2'd2
  } unit_e;

  typedef enum logic {
    ST_ACCEPT = 1'b0,
    ST_HOLD   = 1'b1
  } issue_state_e;

  // Execution unit that runs a given operation
  function automatic unit_e op_unit(op_e op);
    unit_e unit;
    case (op)
      OP_VADD:             unit = UNIT_ALU;
      OP_VMUL:             unit = UNIT_MUL;
      OP_VLOAD, OP_VSTORE: unit = UNIT_LSU;
      default:             unit = UNIT_ALU;
    endcase
    return unit;
  endfunction

endpackage

`default_nettype wire

// ==== hdl/vinsn_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module vinsn_tracker (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  // New instruction entering a unit
  input  logic                                            accept_i,
  input  seq_pkg::unit_e                                  accept_unit_i,
  input  seq_pkg::vid_t                                   accept_id_i,
  // Completion pulses, one vector per unit
  input  seq_pkg::vinsn_vec_t [seq_pkg::NR_UNITS-1:0]     unit_done_i,
  output seq_pkg::vid_t                                   free_id_o,
  output logic                                            id_avail_o,
  output seq_pkg::vinsn_vec_t                             running_o,
  output seq_pkg::unit_vec_t                              unit_done_any_o,
  output logic                                            idle_o
);

  // Running set per unit
  seq_pkg::vinsn_vec_t [seq_pkg::NR_UNITS-1:0] unit_run_d, unit_run_q;

  always_comb begin
    for (int u = 0; u < seq_pkg::NR_UNITS; u++) begin
      // Drop IDs the unit reports done
      unit_run_d[u] = unit_run_q[u] & ~unit_done_i[u];
      // Mark the new ID on its target unit
      if (accept_i && (int'(accept_unit_i) == u)) begin
        unit_run_d[u][accept_id_i] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      unit_run_q <= '0;
    end else begin
      unit_run_q <= unit_run_d;
    end
  end

  // Global running set and per-unit done summary
  always_comb begin
    running_o = '0;
    for (int u = 0; u < seq_pkg::NR_UNITS; u++) begin
      running_o          |= unit_run_q[u];
      unit_done_any_o[u]  = |unit_done_i[u];
    end
  end

  //////////////////////////////////////////////////
  // Free ID selection
  //////////////////////////////////////////////////

  // Walk downwards so the lowest clear bit wins
  always_comb begin
    free_id_o = '0;
    for (int i = seq_pkg::NR_VINSN - 1; i >= 0; i--) begin
      if (!running_o[i]) begin
        free_id_o = seq_pkg::vid_t'(i);
      end
    end
  end

  // All IDs taken means no accept
  assign id_avail_o = ~&running_o;
  assign idle_o     = ~|running_o;

endmodule

`default_nettype wire

// ==== hdl/vreg_scoreboard.sv ====
`timescale 1ns/1ps
`default_nettype none

module vreg_scoreboard (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  logic                                            accept_i,
  input  seq_pkg::vid_t                                   accept_id_i,
  // Incoming request
  input  seq_pkg::vreg_t                                  req_vs1_i,
  input  seq_pkg::vreg_t                                  req_vs2_i,
  input  seq_pkg::vreg_t                                  req_vd_i,
  input  logic                                            req_use_vs1_i,
  input  logic                                            req_use_vs2_i,
  input  logic                                            req_use_vd_i,
  input  logic                                            req_vm_i,
  input  seq_pkg::vinsn_vec_t                             running_i,
  // Per-operand hazards of the incoming request
  output seq_pkg::vinsn_vec_t                             hazard_vs1_o,
  output seq_pkg::vinsn_vec_t                             hazard_vs2_o,
  output seq_pkg::vinsn_vec_t                             hazard_vd_o,
  output seq_pkg::vinsn_vec_t                             hazard_vm_o,
  output seq_pkg::vinsn_vec_t [seq_pkg::NR_VINSN-1:0]     hazard_table_o
);

  //////////////////////////////////////////////////
  // Register access lists
  //////////////////////////////////////////////////

  // Last writer and last reader of each register
  seq_pkg::vid_t                 wr_vid_q [seq_pkg::NR_VREGS];
  seq_pkg::vid_t                 rd_vid_q [seq_pkg::NR_VREGS];
  logic [seq_pkg::NR_VREGS-1:0]  wr_vld_q, rd_vld_q;
  logic [seq_pkg::NR_VREGS-1:0]  wr_vld_d, rd_vld_d;
  // Entries whose ID is still running
  logic [seq_pkg::NR_VREGS-1:0]  wr_vld, rd_vld;

  seq_pkg::vinsn_vec_t [seq_pkg::NR_VINSN-1:0] table_d;

  always_comb begin
    for (int r = 0; r < seq_pkg::NR_VREGS; r++) begin
      wr_vld[r] = wr_vld_q[r] & running_i[wr_vid_q[r]];
      rd_vld[r] = rd_vld_q[r] & running_i[rd_vid_q[r]];
    end
  end

  // Hazards from the expired-filtered lists
  always_comb begin
    hazard_vs1_o = '0;
    hazard_vs2_o = '0;
    hazard_vd_o  = '0;
    hazard_vm_o  = '0;
    // RAW on sources and on v0 when masked
    if (req_use_vs1_i && wr_vld[req_vs1_i]) hazard_vs1_o[wr_vid_q[req_vs1_i]] = 1'b1;
    if (req_use_vs2_i && wr_vld[req_vs2_i]) hazard_vs2_o[wr_vid_q[req_vs2_i]] = 1'b1;
    if (!req_vm_i && wr_vld[seq_pkg::VMASK]) begin
      hazard_vm_o[wr_vid_q[seq_pkg::VMASK]] = 1'b1;
    end
    if (req_use_vd_i) begin
      // WAR goes on every source vector
      if (rd_vld[req_vd_i]) begin
        hazard_vs1_o[rd_vid_q[req_vd_i]] = 1'b1;
        hazard_vs2_o[rd_vid_q[req_vd_i]] = 1'b1;
        hazard_vm_o[rd_vid_q[req_vd_i]]  = 1'b1;
      end
      // WAW
      if (wr_vld[req_vd_i]) hazard_vd_o[wr_vid_q[req_vd_i]] = 1'b1;
    end
  end

  // Record the new instruction as writer and reader
  always_comb begin
    wr_vld_d = wr_vld;
    rd_vld_d = rd_vld;
    if (accept_i) begin
      if (req_use_vd_i)  wr_vld_d[req_vd_i]  = 1'b1;
      if (req_use_vs1_i) rd_vld_d[req_vs1_i] = 1'b1;
      if (req_use_vs2_i) rd_vld_d[req_vs2_i] = 1'b1;
      if (!req_vm_i)     rd_vld_d[seq_pkg::VMASK] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept_i) begin
      if (req_use_vd_i)  wr_vid_q[req_vd_i]  <= accept_id_i;
      if (req_use_vs1_i) rd_vid_q[req_vs1_i] <= accept_id_i;
      if (req_use_vs2_i) rd_vid_q[req_vs2_i] <= accept_id_i;
      if (!req_vm_i)     rd_vid_q[seq_pkg::VMASK] <= accept_id_i;
    end
  end

  //////////////////////////////////////////////////
  // Global hazard table
  //////////////////////////////////////////////////

  // Row N lists the IDs that instruction N waits on
  always_comb begin
    for (int i = 0; i < seq_pkg::NR_VINSN; i++) begin
      // Finished columns drop out, a finished row empties
      table_d[i] = running_i[i] ? (hazard_table_o[i] & running_i) : '0;
    end
    if (accept_i) begin
      table_d[accept_id_i] = hazard_vs1_o | hazard_vs2_o | hazard_vd_o | hazard_vm_o;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_vld_q       <= '0;
      rd_vld_q       <= '0;
      hazard_table_o <= '0;
    end else begin
      wr_vld_q       <= wr_vld_d;
      rd_vld_q       <= rd_vld_d;
      hazard_table_o <= table_d;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/unit_queue_cnt.sv ====
`timescale 1ns/1ps
`default_nettype none

module unit_queue_cnt #(
  parameter int unsigned QUEUE_DEPTH = 2
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               accept_i,
  input  seq_pkg::unit_e     accept_unit_i,
  // One done summary bit per unit
  input  seq_pkg::unit_vec_t unit_done_any_i,
  output seq_pkg::unit_vec_t unit_ready_o
);

  // Wide enough to hold QUEUE_DEPTH itself
  localparam int unsigned       CNT_W   = $clog2(QUEUE_DEPTH + 1);
  localparam logic [CNT_W-1:0]  CNT_MAX = CNT_W'(QUEUE_DEPTH);

  for (genvar u = 0; u < seq_pkg::NR_UNITS; u++) begin : gen_cnt
    logic             cnt_up;
    logic             cnt_down;
    logic [CNT_W-1:0] cnt_q;

    assign cnt_up   = accept_i && (accept_unit_i == seq_pkg::unit_e'(u));
    assign cnt_down = unit_done_any_i[u];

    // Saturating at both ends, an accept and a done cancel out
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q <= '0;
      end else if (cnt_up && !cnt_down && (cnt_q != CNT_MAX)) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (cnt_down && !cnt_up && (cnt_q != '0)) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end

    // Room for one more instruction on this unit
    assign unit_ready_o[u] = (cnt_q < CNT_MAX);
  end

endmodule

`default_nettype wire

// ==== hdl/issue_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Dispatcher request
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  seq_pkg::op_e        req_op_i,
  input  seq_pkg::vreg_t      req_vs1_i,
  input  seq_pkg::vreg_t      req_vs2_i,
  input  seq_pkg::vreg_t      req_vd_i,
  input  logic                req_vm_i,
  // Status from the tracker and counters
  input  seq_pkg::vid_t       free_id_i,
  input  logic                id_avail_i,
  input  seq_pkg::unit_vec_t  unit_ready_i,
  // Hazards of the current request
  input  seq_pkg::vinsn_vec_t hazard_vs1_i,
  input  seq_pkg::vinsn_vec_t hazard_vs2_i,
  input  seq_pkg::vinsn_vec_t hazard_vd_i,
  input  seq_pkg::vinsn_vec_t hazard_vm_i,
  output logic                accept_o,
  output seq_pkg::unit_e      accept_unit_o,
  // Request towards the units
  output logic                pe_req_valid_o,
  input  logic                pe_req_ready_i,
  output seq_pkg::vid_t       pe_id_o,
  output seq_pkg::op_e        pe_op_o,
  output seq_pkg::vreg_t      pe_vs1_o,
  output seq_pkg::vreg_t      pe_vs2_o,
  output seq_pkg::vreg_t      pe_vd_o,
  output logic                pe_vm_o,
  output seq_pkg::vinsn_vec_t pe_hazard_vs1_o,
  output seq_pkg::vinsn_vec_t pe_hazard_vs2_o,
  output seq_pkg::vinsn_vec_t pe_hazard_vd_o,
  output seq_pkg::vinsn_vec_t pe_hazard_vm_o
);

  seq_pkg::issue_state_e state_d, state_q;

  assign accept_unit_o = seq_pkg::op_unit(req_op_i);

  // Free slot, free ID and room on the target unit
  assign req_ready_o = (state_q == seq_pkg::ST_ACCEPT) && id_avail_i &&
                       unit_ready_i[accept_unit_o];
  assign accept_o    = req_valid_i && req_ready_o;

  //////////////////////////////////////////////////
  // Accept / hold FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      seq_pkg::ST_ACCEPT: if (accept_o) state_d = seq_pkg::ST_HOLD;
      // Leave once the units take the request
      seq_pkg::ST_HOLD:   if (pe_req_ready_i) state_d = seq_pkg::ST_ACCEPT;
      default:            state_d = seq_pkg::ST_ACCEPT;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= seq_pkg::ST_ACCEPT;
    end else begin
      state_q <= state_d;
    end
  end

  // Request is pending exactly while holding
  assign pe_req_valid_o = (state_q == seq_pkg::ST_HOLD);

  // Payload captured on accept, frozen while holding
  always_ff @(posedge clk_i) begin
    if (accept_o) begin
      pe_id_o         <= free_id_i;
      pe_op_o         <= req_op_i;
      pe_vs1_o        <= req_vs1_i;
      pe_vs2_o        <= req_vs2_i;
      pe_vd_o         <= req_vd_i;
      pe_vm_o         <= req_vm_i;
      pe_hazard_vs1_o <= hazard_vs1_i;
      pe_hazard_vs2_o <= hazard_vs2_i;
      pe_hazard_vd_o  <= hazard_vd_i;
      pe_hazard_vm_o  <= hazard_vm_i;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/vector_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module vector_sequencer #(
  parameter int unsigned QUEUE_DEPTH = 2
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  // Dispatcher side
  input  logic                                        req_valid_i,
  output logic                                        req_ready_o,
  input  seq_pkg::op_e                                req_op_i,
  input  seq_pkg::vreg_t                              req_vs1_i,
  input  seq_pkg::vreg_t                              req_vs2_i,
  input  seq_pkg::vreg_t                              req_vd_i,
  input  logic                                        req_use_vs1_i,
  input  logic                                        req_use_vs2_i,
  input  logic                                        req_use_vd_i,
  input  logic                                        req_vm_i,
  // Unit side
  output logic                                        pe_req_valid_o,
  output seq_pkg::vid_t                               pe_id_o,
  output seq_pkg::op_e                                pe_op_o,
  output seq_pkg::vreg_t                              pe_vs1_o,
  output seq_pkg::vreg_t                              pe_vs2_o,
  output seq_pkg::vreg_t                              pe_vd_o,
  output logic                                        pe_vm_o,
  output seq_pkg::vinsn_vec_t                         pe_hazard_vs1_o,
  output seq_pkg::vinsn_vec_t                         pe_hazard_vs2_o,
  output seq_pkg::vinsn_vec_t                         pe_hazard_vd_o,
  output seq_pkg::vinsn_vec_t                         pe_hazard_vm_o,
  input  logic                                        pe_req_ready_i,
  input  seq_pkg::vinsn_vec_t [seq_pkg::NR_UNITS-1:0] unit_done_i,
  // Status
  output seq_pkg::vinsn_vec_t                         vinsn_running_o,
  output seq_pkg::vinsn_vec_t [seq_pkg::NR_VINSN-1:0] hazard_table_o,
  output logic                                        idle_o
);

  logic                accept;
  seq_pkg::unit_e      accept_unit;
  seq_pkg::vid_t       free_id;
  logic                id_avail;
  seq_pkg::unit_vec_t  unit_done_any;
  seq_pkg::unit_vec_t  unit_ready;
  seq_pkg::vinsn_vec_t hazard_vs1, hazard_vs2, hazard_vd, hazard_vm;

  issue_ctrl u_issue_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_op_i        (req_op_i),
    .req_vs1_i       (req_vs1_i),
    .req_vs2_i       (req_vs2_i),
    .req_vd_i        (req_vd_i),
    .req_vm_i        (req_vm_i),
    .free_id_i       (free_id),
    .id_avail_i      (id_avail),
    .unit_ready_i    (unit_ready),
    .hazard_vs1_i    (hazard_vs1),
    .hazard_vs2_i    (hazard_vs2),
    .hazard_vd_i     (hazard_vd),
    .hazard_vm_i     (hazard_vm),
    .accept_o        (accept),
    .accept_unit_o   (accept_unit),
    .pe_req_valid_o  (pe_req_valid_o),
    .pe_req_ready_i  (pe_req_ready_i),
    .pe_id_o         (pe_id_o),
    .pe_op_o         (pe_op_o),
    .pe_vs1_o        (pe_vs1_o),
    .pe_vs2_o        (pe_vs2_o),
    .pe_vd_o         (pe_vd_o),
    .pe_vm_o         (pe_vm_o),
    .pe_hazard_vs1_o (pe_hazard_vs1_o),
    .pe_hazard_vs2_o (pe_hazard_vs2_o),
    .pe_hazard_vd_o  (pe_hazard_vd_o),
    .pe_hazard_vm_o  (pe_hazard_vm_o)
  );

  // Accepted ID is the current free ID
  vinsn_tracker u_vinsn_tracker (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .accept_i        (accept),
    .accept_unit_i   (accept_unit),
    .accept_id_i     (free_id),
    .unit_done_i     (unit_done_i),
    .free_id_o       (free_id),
    .id_avail_o      (id_avail),
    .running_o       (vinsn_running_o),
    .unit_done_any_o (unit_done_any),
    .idle_o          (idle_o)
  );

  vreg_scoreboard u_vreg_scoreboard (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .accept_i       (accept),
    .accept_id_i    (free_id),
    .req_vs1_i      (req_vs1_i),
    .req_vs2_i      (req_vs2_i),
    .req_vd_i       (req_vd_i),
    .req_use_vs1_i  (req_use_vs1_i),
    .req_use_vs2_i  (req_use_vs2_i),
    .req_use_vd_i   (req_use_vd_i),
    .req_vm_i       (req_vm_i),
    .running_i      (vinsn_running_o),
    .hazard_vs1_o   (hazard_vs1),
    .hazard_vs2_o   (hazard_vs2),
    .hazard_vd_o    (hazard_vd),
    .hazard_vm_o    (hazard_vm),
    .hazard_table_o (hazard_table_o)
  );

  unit_queue_cnt #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_unit_queue_cnt (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .accept_i        (accept),
    .accept_unit_i   (accept_unit),
    .unit_done_any_i (unit_done_any),
    .unit_ready_o    (unit_ready)
  );

endmodule

`default_nettype wire

// ==== tb/tb_vector_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vector_sequencer;

  localparam int unsigned QUEUE_DEPTH = 2;
  localparam int          CLK_NS      = 20;
  // Instructions issued over the whole run
  localparam int          NR_INSN     = 45;

  logic                                        clk_i;
  logic                                        rst_ni;
  logic                                        req_valid_i;
  logic                                        req_ready_o;
  seq_pkg::op_e                                req_op_i;
  seq_pkg::vreg_t                              req_vs1_i, req_vs2_i, req_vd_i;
  logic                                        req_use_vs1_i, req_use_vs2_i, req_use_vd_i;
  logic                                        req_vm_i;
  logic                                        pe_req_valid_o, pe_req_ready_i, pe_vm_o;
  seq_pkg::vid_t                               pe_id_o;
  seq_pkg::op_e                                pe_op_o;
  seq_pkg::vreg_t                              pe_vs1_o, pe_vs2_o, pe_vd_o;
  seq_pkg::vinsn_vec_t                         pe_hazard_vs1_o, pe_hazard_vs2_o;
  seq_pkg::vinsn_vec_t                         pe_hazard_vd_o, pe_hazard_vm_o;
  seq_pkg::vinsn_vec_t [seq_pkg::NR_UNITS-1:0] unit_done_i;
  seq_pkg::vinsn_vec_t                         vinsn_running_o;
  seq_pkg::vinsn_vec_t [seq_pkg::NR_VINSN-1:0] hazard_table_o;
  logic                                        idle_o;

  vector_sequencer #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_vector_sequencer (.*);

  //////////////////////////////////////////////////
  // Reference model state
  //////////////////////////////////////////////////

  seq_pkg::vinsn_vec_t m_run [seq_pkg::NR_UNITS];
  int unsigned         m_cnt [seq_pkg::NR_UNITS];
  seq_pkg::vid_t       m_wr_id [seq_pkg::NR_VREGS];
  seq_pkg::vid_t       m_rd_id [seq_pkg::NR_VREGS];
  logic [seq_pkg::NR_VREGS-1:0] m_wr_v, m_rd_v;
  seq_pkg::vinsn_vec_t m_tab [seq_pkg::NR_VINSN];
  // Model of the pending request towards the units
  logic                m_hold;
  seq_pkg::vid_t       m_pe_id;
  seq_pkg::op_e        m_pe_op;
  seq_pkg::vreg_t      m_pe_vs1, m_pe_vs2, m_pe_vd;
  logic                m_pe_vm;
  seq_pkg::vinsn_vec_t m_pe_h1, m_pe_h2, m_pe_hd, m_pe_hm;

  function automatic int unit_of(seq_pkg::op_e op);
    // Loads and stores share the LSU
    if (op == seq_pkg::OP_VADD) return 0;
    if (op == seq_pkg::OP_VMUL) return 1;
    return 2;
  endfunction

  function automatic seq_pkg::vinsn_vec_t running_all();
    seq_pkg::vinsn_vec_t r;
    r = '0;
    for (int u = 0; u < seq_pkg::NR_UNITS; u++) r = r | m_run[u];
    return r;
  endfunction

  // First clear bit counting up from ID 0
  function automatic seq_pkg::vid_t lowest_free(seq_pkg::vinsn_vec_t busy);
    seq_pkg::vid_t id;
    logic          found;
    id    = '0;
    found = 1'b0;
    for (int i = 0; i < seq_pkg::NR_VINSN; i++) begin
      if (!busy[i] && !found) begin
        id    = seq_pkg::vid_t'(i);
        found = 1'b1;
      end
    end
    return id;
  endfunction

  // Expected hazards of the request now on the dispatcher port
  function automatic void ref_hazards(input seq_pkg::vinsn_vec_t run,
                                      output seq_pkg::vinsn_vec_t h1,
                                      output seq_pkg::vinsn_vec_t h2,
                                      output seq_pkg::vinsn_vec_t hd,
                                      output seq_pkg::vinsn_vec_t hm);
    h1 = '0;
    h2 = '0;
    hd = '0;
    hm = '0;
    // RAW on each used source
    if (req_use_vs1_i && m_wr_v[req_vs1_i] && run[m_wr_id[req_vs1_i]]) h1[m_wr_id[req_vs1_i]] = 1;
    if (req_use_vs2_i && m_wr_v[req_vs2_i] && run[m_wr_id[req_vs2_i]]) h2[m_wr_id[req_vs2_i]] = 1;
    if (!req_vm_i && m_wr_v[0] && run[m_wr_id[0]]) hm[m_wr_id[0]] = 1;
    if (req_use_vd_i && m_rd_v[req_vd_i] && run[m_rd_id[req_vd_i]]) begin
      h1[m_rd_id[req_vd_i]] = 1;
      h2[m_rd_id[req_vd_i]] = 1;
      hm[m_rd_id[req_vd_i]] = 1;
    end
    // WAW
    if (req_use_vd_i && m_wr_v[req_vd_i] && run[m_wr_id[req_vd_i]]) hd[m_wr_id[req_vd_i]] = 1;
  endfunction

  // Model advances on the inputs seen at each rising edge
  always @(posedge clk_i) begin : model_step
    seq_pkg::vinsn_vec_t run, h1, h2, hd, hm;
    seq_pkg::vid_t       id;
    int                  u;
    logic                acc, up, dn;
    run = running_all();
    ref_hazards(run, h1, h2, hd, hm);
    id  = lowest_free(run);
    u   = unit_of(req_op_i);
    acc = rst_ni && req_valid_i && !m_hold && (run != '1) && (m_cnt[u] < QUEUE_DEPTH);
    if (!rst_ni) begin
      for (int i = 0; i < seq_pkg::NR_UNITS; i++) begin
        m_run[i] = '0;
        m_cnt[i] = 0;
      end
      for (int i = 0; i < seq_pkg::NR_VINSN; i++) m_tab[i] = '0;
      m_wr_v = '0;
      m_rd_v = '0;
      m_hold = 1'b0;
    end else begin
      // Entries and rows of finished IDs drop out
      for (int r = 0; r < seq_pkg::NR_VREGS; r++) begin
        if (!run[m_wr_id[r]]) m_wr_v[r] = 1'b0;
        if (!run[m_rd_id[r]]) m_rd_v[r] = 1'b0;
      end
      for (int i = 0; i < seq_pkg::NR_VINSN; i++) m_tab[i] = run[i] ? (m_tab[i] & run) : '0;
      if (acc) begin
        if (req_use_vd_i) begin
          m_wr_id[req_vd_i] = id;
          m_wr_v[req_vd_i]  = 1'b1;
        end
        if (req_use_vs1_i) begin
          m_rd_id[req_vs1_i] = id;
          m_rd_v[req_vs1_i]  = 1'b1;
        end
        if (req_use_vs2_i) begin
          m_rd_id[req_vs2_i] = id;
          m_rd_v[req_vs2_i]  = 1'b1;
        end
        if (!req_vm_i) begin
          m_rd_id[0] = id;
          m_rd_v[0]  = 1'b1;
        end
        m_tab[id] = h1 | h2 | hd | hm;
        m_pe_id   = id;
        m_pe_op   = req_op_i;
        m_pe_vs1  = req_vs1_i;
        m_pe_vs2  = req_vs2_i;
        m_pe_vd   = req_vd_i;
        m_pe_vm   = req_vm_i;
        m_pe_h1   = h1;
        m_pe_h2   = h2;
        m_pe_hd   = hd;
        m_pe_hm   = hm;
      end
      for (int i = 0; i < seq_pkg::NR_UNITS; i++) begin
        up = acc && (u == i);
        dn = |unit_done_i[i];
        if (up && !dn && m_cnt[i] < QUEUE_DEPTH) m_cnt[i] = m_cnt[i] + 1;
        else if (dn && !up && m_cnt[i] > 0) m_cnt[i] = m_cnt[i] - 1;
        m_run[i] = m_run[i] & ~unit_done_i[i];
      end
      if (acc) m_run[u][id] = 1'b1;
      // Hold until the units take the request
      if (!m_hold && acc) m_hold = 1'b1;
      else if (m_hold && pe_req_ready_i) m_hold = 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic fail_run();
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_vid(string name, seq_pkg::vid_t exp, seq_pkg::vid_t act);
    if (exp !== act) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_vreg(string name, seq_pkg::vreg_t exp, seq_pkg::vreg_t act);
    if (exp !== act) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_op(string name, seq_pkg::op_e exp, seq_pkg::op_e act);
    if (exp !== act) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_vec(string name, seq_pkg::vinsn_vec_t exp, seq_pkg::vinsn_vec_t act);
    if (exp !== act) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      fail_run();
    end
  endtask

  // Outputs have settled by mid-cycle
  always @(negedge clk_i) begin : compare_outputs
    seq_pkg::vinsn_vec_t run;
    logic                exp_ready;
    if (rst_ni) begin
      run       = running_all();
      exp_ready = !m_hold && (run != '1) && (m_cnt[unit_of(req_op_i)] < QUEUE_DEPTH);
      check_bit("req_ready_o", exp_ready, req_ready_o);
      check_bit("pe_req_valid_o", m_hold, pe_req_valid_o);
      check_bit("idle_o", (run == '0), idle_o);
      check_vec("vinsn_running_o", run, vinsn_running_o);
      for (int i = 0; i < seq_pkg::NR_VINSN; i++) begin
        check_vec($sformatf("hazard_table_o[%0d]", i), m_tab[i], hazard_table_o[i]);
      end
      if (m_hold) begin
        check_vid("pe_id_o", m_pe_id, pe_id_o);
        check_op("pe_op_o", m_pe_op, pe_op_o);
        check_vreg("pe_vs1_o", m_pe_vs1, pe_vs1_o);
        check_vreg("pe_vs2_o", m_pe_vs2, pe_vs2_o);
        check_vreg("pe_vd_o", m_pe_vd, pe_vd_o);
        check_bit("pe_vm_o", m_pe_vm, pe_vm_o);
        check_vec("pe_hazard_vs1_o", m_pe_h1, pe_hazard_vs1_o);
        check_vec("pe_hazard_vs2_o", m_pe_h2, pe_hazard_vs2_o);
        check_vec("pe_hazard_vd_o", m_pe_hd, pe_hazard_vd_o);
        check_vec("pe_hazard_vm_o", m_pe_hm, pe_hazard_vm_o);
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic present(seq_pkg::op_e op, int vs1, int vs2, int vd,
                         logic u1, logic u2, logic ud, logic vm);
    req_op_i      = op;
    req_vs1_i     = seq_pkg::vreg_t'(vs1);
    req_vs2_i     = seq_pkg::vreg_t'(vs2);
    req_vd_i      = seq_pkg::vreg_t'(vd);
    req_use_vs1_i = u1;
    req_use_vs2_i = u2;
    req_use_vd_i  = ud;
    req_vm_i      = vm;
    req_valid_i   = 1'b1;
  endtask

  // Returns just after the handshake edge
  task automatic wait_accept();
    logic rdy;
    do begin
      @(negedge clk_i);
      rdy = req_ready_o;
      @(posedge clk_i);
      #2;
    end while (!rdy);
    req_valid_i = 1'b0;
  endtask

  task automatic send(seq_pkg::op_e op, int vs1, int vs2, int vd,
                      logic u1, logic u2, logic ud, logic vm);
    present(op, vs1, vs2, vd, u1, u2, ud, vm);
    wait_accept();
  endtask

  task automatic done_pulse(int u, seq_pkg::vid_t id);
    unit_done_i[u][id] = 1'b1;
    @(posedge clk_i);
    #2;
    unit_done_i = '0;
  endtask

  // Request stays refused for n cycles
  task automatic expect_blocked(int n);
    repeat (n) begin
      @(negedge clk_i);
      check_bit("req_ready_o", 1'b0, req_ready_o);
      @(posedge clk_i);
      #2;
    end
  endtask

  task automatic retire_all();
    for (int u = 0; u < seq_pkg::NR_UNITS; u++) begin
      while (m_run[u] != '0) done_pulse(u, lowest_free(~m_run[u]));
    end
    @(negedge clk_i);
    check_bit("idle_o", 1'b1, idle_o);
    @(posedge clk_i);
    #2;
  endtask

  initial begin
    clk_i = 1'b0;
    forever #(CLK_NS / 2) clk_i = ~clk_i;
  end

  // Watchdog
  initial begin
    #(NR_INSN * 40 * CLK_NS);
    $display("Timeout: the run did not finish in time");
    fail_run();
  end

  initial begin
    seq_pkg::op_e op;
    int           u;
    void'($urandom(32'hf0415fb7));
    rst_ni         = 1'b0;
    pe_req_ready_i = 1'b1;
    unit_done_i    = '0;
    present(seq_pkg::OP_VADD, 0, 0, 0, 0, 0, 0, 1);
    req_valid_i    = 1'b0;
    repeat (3) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    // Independent instructions take IDs 0, 1, 2 with no hazards
    send(seq_pkg::OP_VADD, 1, 2, 10, 1, 1, 1, 1);
    check_vid("pe_id_o", 3'd0, pe_id_o);
    send(seq_pkg::OP_VADD, 4, 5, 11, 1, 1, 1, 1);
    check_vid("pe_id_o", 3'd1, pe_id_o);
    send(seq_pkg::OP_VMUL, 6, 7, 12, 1, 1, 1, 1);
    check_vid("pe_id_o", 3'd2, pe_id_o);
    check_vec("pe_hazard_vs1_o", 8'h00, pe_hazard_vs1_o);
    check_vec("pe_hazard_vs2_o", 8'h00, pe_hazard_vs2_o);
    check_vec("pe_hazard_vd_o", 8'h00, pe_hazard_vd_o);
    check_vec("pe_hazard_vm_o", 8'h00, pe_hazard_vm_o);
    retire_all();

    // Writer of v0 followed by load, add and store around v3 and a masked multiply
    send(seq_pkg::OP_VADD, 1, 2, 0, 1, 1, 1, 1);
    send(seq_pkg::OP_VLOAD, 0, 0, 3, 0, 0, 1, 1);
    send(seq_pkg::OP_VADD, 3, 4, 5, 1, 1, 1, 1);
    check_vec("pe_hazard_vs1_o", 8'h02, pe_hazard_vs1_o);
    send(seq_pkg::OP_VSTORE, 3, 0, 0, 1, 0, 0, 1);
    send(seq_pkg::OP_VMUL, 6, 7, 3, 1, 1, 1, 0);
    check_vec("pe_hazard_vm_o", 8'h09, pe_hazard_vm_o);
    check_vec("pe_hazard_vd_o", 8'h02, pe_hazard_vd_o);
    check_vec("pe_hazard_vs1_o", 8'h08, pe_hazard_vs1_o);

    // Freed ID 2 is reused
    done_pulse(0, 3'd2);
    send(seq_pkg::OP_VADD, 3, 4, 8, 1, 1, 1, 1);
    check_vid("pe_id_o", 3'd2, pe_id_o);
    check_vec("pe_hazard_vs1_o", 8'h10, pe_hazard_vs1_o);
    retire_all();

    // ALU queue full while the LSU still accepts
    send(seq_pkg::OP_VADD, 1, 2, 3, 1, 1, 1, 1);
    send(seq_pkg::OP_VADD, 4, 5, 6, 1, 1, 1, 1);
    present(seq_pkg::OP_VADD, 7, 8, 9, 1, 1, 1, 1);
    expect_blocked(3);
    req_valid_i = 1'b0;
    send(seq_pkg::OP_VLOAD, 0, 0, 12, 0, 0, 1, 1);
    present(seq_pkg::OP_VADD, 7, 8, 9, 1, 1, 1, 1);
    expect_blocked(2);
    done_pulse(0, 3'd0);
    wait_accept();
    retire_all();

    // Back-pressure from the units
    pe_req_ready_i = 1'b0;
    send(seq_pkg::OP_VMUL, 1, 2, 3, 1, 1, 1, 1);
    repeat (4) begin
      @(negedge clk_i);
      check_bit("pe_req_valid_o", 1'b1, pe_req_valid_o);
      check_bit("req_ready_o", 1'b0, req_ready_o);
    end
    @(posedge clk_i);
    #2;
    pe_req_ready_i = 1'b1;
    retire_all();

    // Every unit full so nothing is accepted until a done pulse
    for (int i = 0; i < 6; i++) begin
      send(seq_pkg::op_e'(i / 2), i, i + 8, i + 16, 1, 1, 1, 1);
    end
    present(seq_pkg::OP_VADD, 1, 2, 20, 1, 1, 1, 1);
    expect_blocked(2);
    present(seq_pkg::OP_VSTORE, 1, 2, 20, 1, 0, 0, 1);
    expect_blocked(2);
    done_pulse(2, lowest_free(~m_run[2]));
    wait_accept();
    retire_all();

    // Random traffic with random completion times
    repeat (24) begin
      op = seq_pkg::op_e'($urandom_range(3, 0));
      u  = unit_of(op);
      if (m_cnt[u] >= QUEUE_DEPTH) done_pulse(u, lowest_free(~m_run[u]));
      send(op, int'($urandom_range(7, 0)), int'($urandom_range(7, 0)),
           int'($urandom_range(7, 0)), 1'($urandom_range(1, 0)),
           1'($urandom_range(1, 0)), 1'($urandom_range(1, 0)), 1'($urandom_range(1, 0)));
      u = int'($urandom_range(2, 0));
      if ($urandom_range(1, 0) == 1 && m_run[u] != '0) done_pulse(u, lowest_free(~m_run[u]));
      repeat ($urandom_range(2, 0)) @(posedge clk_i);
      #2;
    end
    retire_all();

    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/seq_pkg.sv
hdl/vinsn_tracker.sv
hdl/vreg_scoreboard.sv
hdl/unit_queue_cnt.sv
hdl/issue_ctrl.sv
hdl/vector_sequencer.sv
tb/tb_vector_sequencer.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the vector sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f files.f --top-module tb_vector_sequencer -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1
